// File: project.f
+incdir+.
rename_pkg.sv
branchTargetResolve.sv
uTypeResult.sv
pcRedirectArbiter.sv
renameCtrl.sv
renameResolveTop.sv
renameResolveTop_assert.sv
renameResolveTop_tb.sv

// File: Makefile
# Verilator build and run for the rename early-resolution subsystem.

TOP := renameResolveTop_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: renameResolveTop_tb.sv
// Testbench for the rename early-resolution subsystem.
// Applies a table of instructions and commit redirects, predicts the fetch
// redirect, CDB request and flush tag from the stage rules and compares
// them with the DUT one cycle after each sample.

`default_nettype none

`include "rename_params.svh"

module renameResolveTop_tb import rename_pkg::*; ();

  typedef struct {
    renameInst_t inst;                            // Instruction presented to rename.
    redirect_t   commit;                          // Commit redirect in the same cycle.
    string       name;                            // Label used in error lines.
  } stimRow_t;

  logic                  clk;                     // Clock.
  logic                  rstN;                    // Reset, active low.
  renameInst_t           inst;                    // DUT instruction input.
  redirect_t             commitRedirect;          // DUT commit redirect input.
  redirect_t             fetchRedirect;           // DUT redirect to fetch.
  cdbReq_t               cdbReq;                  // DUT CDB request.
  logic [`ROB_TAG_W-1:0] flushTag;                // DUT flush tag.

  stimRow_t              rows[$];                 // Stimulus table.
  int                    squashLeft;              // Samples still to be dropped.
  redirect_t             expRedirect;             // Expected fetch redirect.
  cdbReq_t               expCdb;                  // Expected CDB request.
  logic [`ROB_TAG_W-1:0] expFlushTag;             // Expected flush tag.
  int                    errorCount;              // Failed checks so far.

  renameResolveTop i_renameResolveTop (
    .clk            (clk),
    .rstN           (rstN),
    .inst           (inst),
    .commitRedirect (commitRedirect),
    .fetchRedirect  (fetchRedirect),
    .cdbReq         (cdbReq),
    .flushTag       (flushTag)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;                          // Period of 100 time units.

  task automatic abortRun(input string why);
    $display("=== FAIL ===");
    $fatal(1, "%s", why);
  endtask

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      abortRun({"Output mismatch in ", name});
    end
  endtask

  // Returns in the low phase right after the next rising edge.
  task automatic waitFallingEdge();
    int spins;
    spins = 0;
    while (clk !== 1'b1) begin
      #1;
      spins++;
      if (spins > 200) abortRun("The clock stayed low and no rising edge came.");
    end
    spins = 0;
    while (clk !== 1'b0) begin
      #1;
      spins++;
      if (spins > 200) abortRun("The clock stayed high and no falling edge came.");
    end
  endtask

  task automatic addRow(input string name, input logic valid, input instOp_e op,
                        input logic predTaken, input logic wrongPred,
                        input logic commitValid);
    stimRow_t r;
    r.name             = name;
    r.inst.valid       = valid;
    r.inst.op          = op;
    r.inst.pc          = $urandom & 32'hffff_fffc;          // Word-aligned address.
    r.inst.immExt      = (op == OP_LUI) ? ($urandom & 32'hffff_f000)
                                        : (($urandom & 32'h0000_1ffe) - 32'h0000_1000);
    r.inst.predTaken   = predTaken;
    r.inst.predictedPC = r.inst.pc + r.inst.immExt + (wrongPred ? 32'd8 : 32'd0);
    r.inst.robTag      = `ROB_TAG_W'(rows.size());          // Row index doubles as tag.
    r.commit.valid     = commitValid;
    r.commit.target    = $urandom & 32'hffff_fffc;
    rows.push_back(r);
  endtask

  task automatic buildTable();
    addRow("lui",               1'b1, OP_LUI,    1'b1, 1'b1, 1'b0);
    addRow("auipc",             1'b1, OP_AUIPC,  1'b1, 1'b1, 1'b0);
    addRow("jalHit",            1'b1, OP_JAL,    1'b0, 1'b0, 1'b0);
    addRow("jalr",              1'b1, OP_JALR,   1'b1, 1'b1, 1'b0);
    addRow("branchNotTaken",    1'b1, OP_BRANCH, 1'b0, 1'b1, 1'b0);
    addRow("branchTakenHit",    1'b1, OP_BRANCH, 1'b1, 1'b0, 1'b0);
    addRow("idleLui",           1'b0, OP_LUI,    1'b0, 1'b0, 1'b0);
    addRow("branchMiss",        1'b1, OP_BRANCH, 1'b1, 1'b1, 1'b0);
    addRow("squashLui",         1'b1, OP_LUI,    1'b0, 1'b0, 1'b0);
    addRow("squashAuipc",       1'b1, OP_AUIPC,  1'b0, 1'b0, 1'b0);
    addRow("squashJalMiss",     1'b1, OP_JAL,    1'b0, 1'b1, 1'b0);
    addRow("afterSquashLui",    1'b1, OP_LUI,    1'b0, 1'b0, 1'b0);
    addRow("jalMiss",           1'b1, OP_JAL,    1'b0, 1'b1, 1'b0);
    addRow("squashJalr",        1'b1, OP_JALR,   1'b0, 1'b0, 1'b0);
    addRow("commitInSquash",    1'b1, OP_LUI,    1'b0, 1'b0, 1'b1);
    addRow("restartAuipc",      1'b1, OP_AUIPC,  1'b0, 1'b0, 1'b0);
    addRow("restartJalMiss",    1'b1, OP_JAL,    1'b0, 1'b1, 1'b0);
    addRow("restartJalr",       1'b1, OP_JALR,   1'b0, 1'b0, 1'b0);
    addRow("afterRestartAuipc", 1'b1, OP_AUIPC,  1'b0, 1'b0, 1'b0);
    addRow("commitBeatsRename", 1'b1, OP_BRANCH, 1'b1, 1'b1, 1'b1);
    addRow("squashNone",        1'b1, OP_NONE,   1'b0, 1'b0, 1'b0);
    addRow("squashLuiLate",     1'b1, OP_LUI,    1'b0, 1'b0, 1'b0);
    addRow("squashJalrLate",    1'b1, OP_JALR,   1'b0, 1'b0, 1'b0);
    addRow("finalLui",          1'b1, OP_LUI,    1'b0, 1'b0, 1'b0);
  endtask

  // Stage rules applied to one sampled row.
  task automatic computeExpected(input stimRow_t r);
    logic               live;
    logic               checksTarget;
    logic               misdirect;
    logic [`XLEN_W-1:0] target;
    live         = r.inst.valid && (squashLeft == 0);
    target       = r.inst.pc + r.inst.immExt;
    checksTarget = (r.inst.op == OP_JAL) || ((r.inst.op == OP_BRANCH) && r.inst.predTaken);
    misdirect    = live && checksTarget && (target != r.inst.predictedPC);
    expRedirect  = '0;
    if (r.commit.valid) begin
      expRedirect = r.commit;                     // Commit beats rename.
    end else if (misdirect) begin
      expRedirect.valid  = 1'b1;
      expRedirect.target = target;
    end
    expCdb        = '0;
    expCdb.robTag = r.inst.robTag;
    if (live) begin
      case (r.inst.op)
        OP_LUI:          {expCdb.valid, expCdb.value} = {1'b1, r.inst.immExt};
        OP_AUIPC:        {expCdb.valid, expCdb.value} = {1'b1, target};
        OP_JAL, OP_JALR: {expCdb.valid, expCdb.value} = {1'b1, r.inst.pc + 32'd4};
        default:         expCdb.valid = 1'b0;
      endcase
    end
    if (misdirect) expFlushTag = r.inst.robTag;   // Kept even when commit wins.
    if (expRedirect.valid) begin
      squashLeft = `SQUASH_CYCLES;                // A new redirect restarts the window.
    end else if (squashLeft > 0) begin
      squashLeft--;
    end
  endtask

  task automatic checkOutputs(input string name);
    checkValue({name, " redirect valid"}, expRedirect.valid, fetchRedirect.valid);
    if (expRedirect.valid) begin
      checkValue({name, " redirect target"}, expRedirect.target, fetchRedirect.target);
    end
    checkValue({name, " cdb valid"}, expCdb.valid, cdbReq.valid);
    if (expCdb.valid) begin
      checkValue({name, " cdb tag"}, expCdb.robTag, cdbReq.robTag);
      checkValue({name, " cdb value"}, expCdb.value, cdbReq.value);
    end
    checkValue({name, " flush tag"}, expFlushTag, flushTag);
  endtask

  initial begin
    errorCount     = 0;
    squashLeft     = 0;
    expFlushTag    = '0;
    rstN           = 1'b0;
    inst           = '0;
    commitRedirect = '0;
    void'($urandom(32'h3f51b011));
    buildTable();
    waitFallingEdge();                            // Two rising edges in reset.
    waitFallingEdge();
    checkValue("reset redirect valid", 64'd0, fetchRedirect.valid);
    checkValue("reset cdb valid", 64'd0, cdbReq.valid);
    checkValue("reset flush tag", 64'd0, flushTag);
    rstN = 1'b1;
    foreach (rows[i]) begin
      inst           = rows[i].inst;              // Driven in the low phase.
      commitRedirect = rows[i].commit;
      computeExpected(rows[i]);
      waitFallingEdge();                          // Results are one cycle behind.
      checkOutputs(rows[i].name);
    end
    inst           = '0;
    commitRedirect = '0;
    waitFallingEdge();
    if (errorCount == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: renameResolveTop_assert.sv
// Protocol assertions for the rename early-resolution subsystem.
// Bound to the top level. Checks pulse shape, reset values and the
// quiet CDB during the squash window.

`default_nettype none

`include "rename_params.svh"

module renameResolveAssert import rename_pkg::*; (
  input logic        clk,                         // Core clock.
  input logic        rstN,                        // Synchronous reset, active low.
  input renameInst_t inst,                        // Instruction into rename.
  input redirect_t   commitRedirect,              // Redirect from commit.
  input redirect_t   fetchRedirect,               // Redirect to fetch.
  input cdbReq_t     cdbReq                       // CDB request.
);

  // A redirect is a single pulse unless commit sends another right behind it.
  assert property (@(posedge clk) disable iff (!rstN)
    fetchRedirect.valid && !commitRedirect.valid |=> !fetchRedirect.valid)
    else $error("Fetch redirect held high for two cycles.");

  // Each CDB pulse belongs to an instruction sampled the cycle before.
  assert property (@(posedge clk) disable iff (!rstN)
    cdbReq.valid |-> $past(inst.valid))
    else $error("CDB request without a preceding instruction.");

  assert property (@(posedge clk) !rstN |=> !fetchRedirect.valid && !cdbReq.valid)
    else $error("Valid output during reset.");

  // A commit redirect inside the window only extends it.
  assert property (@(posedge clk) disable iff (!rstN)
    fetchRedirect.valid |=> !cdbReq.valid [*`SQUASH_CYCLES])
    else $error("CDB request inside the squash window.");

endmodule

bind renameResolveTop renameResolveAssert i_renameResolveAssert (
  .clk            (clk),
  .rstN           (rstN),
  .inst           (inst),
  .commitRedirect (commitRedirect),
  .fetchRedirect  (fetchRedirect),
  .cdbReq         (cdbReq)
);

`default_nettype wire

// File: renameResolveTop.sv
// Rename early-resolution subsystem.
// Resolves JAL and predicted-taken branch targets, produces U-type and link
// results for the CDB, and arbitrates fetch redirects against commit.

`default_nettype none

`include "rename_params.svh"

module renameResolveTop import rename_pkg::*; (
  input  logic                  clk,              // Core clock.
  input  logic                  rstN,             // Synchronous reset, active low.
  input  renameInst_t           inst,             // One decoded instruction per cycle.
  input  redirect_t             commitRedirect,   // Redirect from the commit stage.
  output redirect_t             fetchRedirect,    // Restart request to fetch.
  output cdbReq_t               cdbReq,           // Result strobe to the CDB arbiter.
  output logic [`ROB_TAG_W-1:0] flushTag          // Tag of the latest rename misdirect.
);

  logic               accept;                     // Instruction is live.
  logic               misdirect;                  // Target check failed.
  logic [`XLEN_W-1:0] resolvedTarget;             // PC plus immediate.
  redirect_t          renameRedirect;             // Rename side of the arbiter.

  branchTargetResolve i_branchTargetResolve (
    .inst           (inst),
    .misdirect      (misdirect),
    .resolvedTarget (resolvedTarget)
  );

  renameCtrl i_renameCtrl (
    .clk            (clk),
    .rstN           (rstN),
    .inst           (inst),
    .misdirect      (misdirect),
    .resolvedTarget (resolvedTarget),
    .fetchRedirect  (fetchRedirect),              // Feedback that opens the squash window.
    .accept         (accept),
    .renameRedirect (renameRedirect),
    .flushTag       (flushTag)
  );

  uTypeResult i_uTypeResult (
    .clk    (clk),
    .rstN   (rstN),
    .inst   (inst),
    .accept (accept),
    .cdbReq (cdbReq)
  );

  pcRedirectArbiter i_pcRedirectArbiter (
    .clk            (clk),
    .rstN           (rstN),
    .commitRedirect (commitRedirect),
    .renameRedirect (renameRedirect),
    .fetchRedirect  (fetchRedirect)
  );

endmodule

`default_nettype wire

// File: renameCtrl.sv
// Rename resolve control.
// Decides which instructions are live, squashes the cycles after each
// redirect while fetch refills, forms the rename redirect and records the
// ROB tag of the latest rename misdirect.

`default_nettype none

`include "rename_params.svh"

module renameCtrl import rename_pkg::*; (
  input  logic                  clk,              // Core clock.
  input  logic                  rstN,             // Synchronous reset, active low.
  input  renameInst_t           inst,             // Decoded instruction from rename.
  input  logic                  misdirect,        // Target check failed.
  input  logic [`XLEN_W-1:0]    resolvedTarget,   // Correct target from the adder.
  input  redirect_t             fetchRedirect,    // Arbiter output, starts a squash.
  output logic                  accept,           // Instruction is live this cycle.
  output redirect_t             renameRedirect,   // Request to the arbiter.
  output logic [`ROB_TAG_W-1:0] flushTag          // Tag of the latest rename misdirect.
);

  localparam int CntW = $clog2(`SQUASH_CYCLES + 1); // Wide enough for the full window.

  // The redirect cycle itself squashes through fetchRedirect.valid.
  // The counter only covers the cycles that remain after it.
  localparam logic [CntW-1:0] ReloadCnt = CntW'(`SQUASH_CYCLES - 1);

  ctrlState_e            state;                   // Current control state.
  ctrlState_e            stateNext;               // State for the next cycle.
  logic [CntW-1:0]       squashCnt;               // Squash cycles still to come.
  logic [CntW-1:0]       squashCntNext;           // Counter value for the next cycle.
  logic                  acceptedMisdirect;       // Live instruction went the wrong way.
  logic [`ROB_TAG_W-1:0] flushTagQ;               // Register behind flushTag.

  // Fetch output of the redirect cycle is already stale, so it is dropped too.
  assign accept = inst.valid && (state == ST_RUN) && !fetchRedirect.valid;

  assign acceptedMisdirect = accept && misdirect;

  assign renameRedirect = '{valid: acceptedMisdirect, target: resolvedTarget};

  always_comb begin
    stateNext     = state;
    squashCntNext = squashCnt;
    if (fetchRedirect.valid) begin                // Any redirect restarts the window.
      stateNext     = (ReloadCnt != '0) ? ST_SQUASH : ST_RUN;
      squashCntNext = ReloadCnt;
    end else if (state == ST_SQUASH) begin
      squashCntNext = squashCnt - 1'b1;
      if (squashCnt <= CntW'(1)) begin            // This was the last squashed cycle.
        stateNext     = ST_RUN;
        squashCntNext = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      state     <= ST_RUN;
      squashCnt <= '0;
    end else begin
      state     <= stateNext;
      squashCnt <= squashCntNext;
    end
  end

  // flushTag is kept even when a commit redirect wins the same cycle.
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flushTagQ <= '0;
    end else if (acceptedMisdirect) begin
      flushTagQ <= inst.robTag;                   // ROB drops everything younger than this.
    end
  end

  assign flushTag = flushTagQ;

endmodule

`default_nettype wire

// File: pcRedirectArbiter.sv
// PC redirect arbiter.
// Fixed priority select between the commit stage and rename. Commit always
// wins because its redirect comes from an older instruction.

`default_nettype none

`include "rename_params.svh"

module pcRedirectArbiter import rename_pkg::*; (
  input  logic      clk,                          // Core clock.
  input  logic      rstN,                         // Synchronous reset, active low.
  input  redirect_t commitRedirect,               // Redirect from the commit stage.
  input  redirect_t renameRedirect,               // Redirect from early resolution.
  output redirect_t fetchRedirect                 // Registered one-cycle redirect to fetch.
);

  redirect_t          winner;                     // Result of the priority select.
  logic               validQ;                     // Redirect strobe register.
  logic [`XLEN_W-1:0] targetQ;                    // Registered restart address.

  always_comb begin
    winner = renameRedirect;
    if (commitRedirect.valid) begin
      winner = commitRedirect;                    // A younger rename redirect is dropped.
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= winner.valid;                     // Holds for one cycle only.
    end
  end

  always_ff @(posedge clk) begin
    targetQ <= winner.target;                     // Ignored by fetch unless validQ is set.
  end

  // Fetch sees the redirect one cycle after the deciding edge.
  assign fetchRedirect = '{valid: validQ, target: targetQ};

endmodule

`default_nettype wire

// File: uTypeResult.sv
// U-type and link value unit.
// LUI, AUIPC, JAL and JALR need no source operands, so their results are
// formed in rename and sent to the CDB one cycle later with the ROB tag.

`default_nettype none

`include "rename_params.svh"

module uTypeResult import rename_pkg::*; (
  input  logic        clk,                        // Core clock.
  input  logic        rstN,                       // Synchronous reset, active low.
  input  renameInst_t inst,                       // Decoded instruction from rename.
  input  logic        accept,                     // Instruction is live this cycle.
  output cdbReq_t     cdbReq                      // Registered CDB request.
);

  logic                  producesValue;           // Opcode writes a destination register.
  logic [`XLEN_W-1:0]    resultNext;              // Value selected for this instruction.
  logic                  validQ;                  // Strobe register.
  logic [`ROB_TAG_W-1:0] robTagQ;                 // Tag held with the value.
  logic [`XLEN_W-1:0]    valueQ;                  // Value held for the bus.

  always_comb begin
    producesValue = 1'b1;
    resultNext    = inst.pc + `XLEN_W'd4;         // Link address is the default.
    unique case (inst.op)
      OP_LUI:          resultNext = inst.immExt;  // Immediate already shifted by decode.
      OP_AUIPC:        resultNext = inst.pc + inst.immExt;
      OP_JAL, OP_JALR: resultNext = inst.pc + `XLEN_W'd4;
      default:         producesValue = 1'b0;      // Branches and others write nothing.
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      validQ <= 1'b0;
    end else begin
      validQ <= accept && producesValue;          // Pulses for one cycle per instruction.
    end
  end

  // Payload is only meaningful while validQ is high.
  always_ff @(posedge clk) begin
    robTagQ <= inst.robTag;
    valueQ  <= resultNext;
  end

  assign cdbReq = '{valid: validQ, robTag: robTagQ, value: valueQ};

endmodule

`default_nettype wire

// File: branchTargetResolve.sv
// Early branch target resolution.
// Adds PC and immediate for JAL and predicted-taken branches and flags
// a misdirect when fetch went somewhere else. Purely combinational.

`default_nettype none

`include "rename_params.svh"

module branchTargetResolve import rename_pkg::*; (
  input  renameInst_t        inst,              // Decoded instruction from rename.
  output logic               misdirect,         // Fetch followed the wrong path.
  output logic [`XLEN_W-1:0] resolvedTarget     // PC plus extended immediate.
);

  logic isJal;                                  // Jump with a known target.
  logic isTakenBranch;                          // Branch that fetch followed as taken.
  logic checksTarget;                           // Opcode whose target is verified here.
  logic targetDiffers;                          // Sum disagrees with the prediction.

  // The adder runs on every opcode. Only the compare result is qualified.
  assign resolvedTarget = inst.pc + inst.immExt;

  always_comb begin
    isJal         = (inst.op == OP_JAL);
    isTakenBranch = (inst.op == OP_BRANCH) && inst.predTaken; // Not-taken ones wait for execute.
    checksTarget  = isJal || isTakenBranch;
    targetDiffers = (resolvedTarget != inst.predictedPC);
    misdirect     = checksTarget && targetDiffers;       // Liveness is checked by renameCtrl.
  end

  // JALR targets depend on a register operand.
  // They are resolved later in the pipeline, so JALR never misdirects here.

endmodule

`default_nettype wire

// File: rename_pkg.sv
// Rename stage early-resolution types.
// Opcode and control-state enums plus the instruction, redirect and
// CDB request structs shared by every block of the resolve unit.

`default_nettype none

`include "rename_params.svh"

package rename_pkg;

  typedef enum logic [2:0] {
    OP_NONE   = 3'd0,                      // Nothing for this unit to do.
    OP_BRANCH = 3'd1,                      // Conditional branch.
    OP_JAL    = 3'd2,                      // Direct jump with link.
    OP_JALR   = 3'd3,                      // Register jump with link.
    OP_LUI    = 3'd4,                      // Load upper immediate.
    OP_AUIPC  = 3'd5                       // Add upper immediate to PC.
  } instOp_e;

  typedef enum logic {
    ST_RUN    = 1'b0,                      // Instructions flow normally.
    ST_SQUASH = 1'b1                       // Fetch is refilling after a redirect.
  } ctrlState_e;

  typedef struct packed {
    logic                  valid;          // Decoded instruction present this cycle.
    instOp_e               op;             // Opcode class as seen by this unit.
    logic [`XLEN_W-1:0]    pc;             // Address of the instruction.
    logic [`XLEN_W-1:0]    immExt;         // Sign-extended immediate from decode.
    logic                  predTaken;      // Fetch predicted the branch taken.
    logic [`XLEN_W-1:0]    predictedPC;    // Next PC that fetch actually used.
    logic [`ROB_TAG_W-1:0] robTag;         // Reorder-buffer slot of the instruction.
  } renameInst_t;

  typedef struct packed {
    logic               valid;             // Fetch must restart.
    logic [`XLEN_W-1:0] target;            // Address to restart from.
  } redirect_t;

  typedef struct packed {
    logic                  valid;          // One-cycle strobe to the CDB arbiter.
    logic [`ROB_TAG_W-1:0] robTag;         // Slot that receives the value.
    logic [`XLEN_W-1:0]    value;          // Result broadcast on the bus.
  } cdbReq_t;

endpackage

`default_nettype wire

// File: rename_params.svh
// Rename stage early-resolution parameters.
// Shared widths and the squash window length for the resolve unit.

`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// Address and data width of the core.
`define XLEN_W 32

// Reorder-buffer tag width, enough for 32 in-flight entries.
`define ROB_TAG_W 5

// Cycles during which rename drops instructions after a redirect.
// Fetch needs this long to refill from the new address.
`define SQUASH_CYCLES 3

`endif
